/* cache_array/data_store.sv */
module data_store
  import l2_cache_pkg::*;
(
  input  logic      stb,
  input  way_t      way,
  input  index_t    index,
  input  word_off_t word_off,
  input  word_t     pwdata,
  input  logic      word_wr_en,
  input  logic      beat_wr_en,
  input  beat_idx_t beat_idx,
  input  beat_t     mem_rdata,
  output word_t     prdata
);

  // Flat word array, way and set form the line base
  word_t data_mem [DATA_DEPTH];

  logic [$clog2(DATA_DEPTH)-1:0] word_addr;
  logic [$clog2(DATA_DEPTH)-1:0] beat_lo_addr;
  logic [$clog2(DATA_DEPTH)-1:0] beat_hi_addr;

  // Word offset sits in the low bits
  assign word_addr = {way, index, word_off};

  // Beat k fills words 2k and 2k+1
  assign beat_lo_addr = {way, index, beat_idx, 1'b0};
  assign beat_hi_addr = {way, index, beat_idx, 1'b1};

  always_ff @(posedge stb)
  begin
    // Low half is the even word
    if (beat_wr_en)
    begin
      data_mem[beat_lo_addr] <= mem_rdata[WORD_W-1:0];
      data_mem[beat_hi_addr] <= mem_rdata[2*WORD_W-1:WORD_W];
    end
    // Word merge from APB
    if (word_wr_en)
      data_mem[word_addr] <= pwdata;
  end

  // Read every cycle, one cycle from address to data
  always_ff @(posedge stb)
  begin
    prdata <= data_mem[word_addr];
  end

endmodule

/* cache_array/tag_store.sv */
module tag_store
  import l2_cache_pkg::*;
(
  input  logic   stb,
  input  logic   stb_n,
  input  index_t index,
  input  tag_t   tag,
  input  logic   lookup_en,
  input  logic   install,
  input  logic   touch,
  output logic   hit,
  output way_t   way
);

  // Per way, per set state
  logic [NUM_WAYS-1:0][NUM_SETS-1:0] valid_q;
  tag_t tag_mem [NUM_WAYS][NUM_SETS];

  // Tree bits per set, bit 2 is the root
  logic [NUM_SETS-1:0][2:0] plru_q;

  logic       hit_any;
  way_t       hit_way;
  logic       inv_any;
  way_t       inv_way;
  logic [2:0] plru_cur;
  way_t       plru_way;
  way_t       victim_way;

  // Compare all ways of the set
  always_comb
  begin
    hit_any = 1'b0;
    hit_way = '0;
    for (int w = 0; w < NUM_WAYS; w++)
    begin
      if (valid_q[w][index] && (tag_mem[w][index] == tag))
      begin
        hit_any = 1'b1;
        hit_way = way_t'(w);
      end
    end
  end

  // Downward scan so the lowest empty way wins
  always_comb
  begin
    inv_any = 1'b0;
    inv_way = '0;
    for (int w = NUM_WAYS - 1; w >= 0; w--)
    begin
      if (!valid_q[w][index])
      begin
        inv_any = 1'b1;
        inv_way = way_t'(w);
      end
    end
  end

  // Root picks the half, then the leaf bit of that half
  assign plru_cur = plru_q[index];
  assign plru_way = plru_cur[2] ? (plru_cur[0] ? way_t'(3) : way_t'(2))
                                : (plru_cur[1] ? way_t'(1) : way_t'(0));

  assign victim_way = inv_any ? inv_way : plru_way;

  // Registered result, way holds the hit way or the victim
  always_ff @(posedge stb or negedge stb_n)
  begin
    if (!stb_n)
    begin
      hit <= 1'b0;
      way <= '0;
    end
    else if (lookup_en)
    begin
      // Lookup beside an install resolves to the line going in
      if (install)
        hit <= 1'b1;
      else
      begin
        hit <= hit_any;
        way <= hit_any ? hit_way : victim_way;
      end
    end
  end

  always_ff @(posedge stb or negedge stb_n)
  begin
    if (!stb_n)
    begin
      valid_q <= '0;
      plru_q  <= '0;
    end
    else
    begin
      if (install)
        valid_q[way][index] <= 1'b1;
      // Point the tree away from the way just used
      if (touch)
      begin
        case (way)
          2'd0:
          begin
            plru_q[index][2] <= 1'b1;
            plru_q[index][1] <= 1'b1;
          end
          2'd1:
          begin
            plru_q[index][2] <= 1'b1;
            plru_q[index][1] <= 1'b0;
          end
          2'd2:
          begin
            plru_q[index][2] <= 1'b0;
            plru_q[index][0] <= 1'b1;
          end
          default:
          begin
            plru_q[index][2] <= 1'b0;
            plru_q[index][0] <= 1'b0;
          end
        endcase
      end
    end
  end

  always_ff @(posedge stb)
  begin
    if (install)
      tag_mem[way][index] <= tag;
  end

  // Install only follows a miss
  install_after_miss_a: assert property (@(posedge stb) disable iff (!stb_n)
    install |-> !hit)
    else $error("install while a hit is registered");

endmodule

/* common/l2_cache_pkg.sv */
package l2_cache_pkg;

  // Cache geometry
  localparam int NUM_WAYS       = 4;
  localparam int NUM_SETS       = 64;
  localparam int WORDS_PER_LINE = 16;
  localparam int BEATS_PER_LINE = 8;

  // Bus widths
  localparam int ADDR_W = 32;
  localparam int WORD_W = 32;

  // Address field widths, tag takes whatever is left at the top
  localparam int BYTE_OFF_W = 2;
  localparam int WORD_OFF_W = $clog2(WORDS_PER_LINE);
  localparam int INDEX_W    = $clog2(NUM_SETS);
  localparam int TAG_W      = ADDR_W - INDEX_W - WORD_OFF_W - BYTE_OFF_W;

  // Byte offset within one line
  localparam int LINE_OFF_W = WORD_OFF_W + BYTE_OFF_W;

  // Total words held in the data array
  localparam int DATA_DEPTH = NUM_WAYS * NUM_SETS * WORDS_PER_LINE;

  // Byte address on both ports
  typedef logic [ADDR_W-1:0] addr_t;

  // Cache word, also the APB data width
  typedef logic [WORD_W-1:0] word_t;

  // Memory beat, low word first
  typedef logic [2*WORD_W-1:0] beat_t;

  // Address fields
  typedef logic [TAG_W-1:0]      tag_t;
  typedef logic [INDEX_W-1:0]    index_t;
  typedef logic [WORD_OFF_W-1:0] word_off_t;

  // Way select
  typedef logic [$clog2(NUM_WAYS)-1:0] way_t;

  // Beat number within one fill
  typedef logic [$clog2(BEATS_PER_LINE)-1:0] beat_idx_t;

endpackage

/* design/burst_counter.sv */
module burst_counter
  import l2_cache_pkg::*;
(
  input  logic      stb,
  input  logic      stb_n,
  input  logic      fill_active,
  input  logic      mem_valid,
  output logic      beat_wr_en,
  output beat_idx_t beat_idx,
  output logic      last_beat
);

  // Beat accepted in the same cycle it arrives
  assign beat_wr_en = fill_active && mem_valid;

  // Eighth beat of the line
  assign last_beat = beat_wr_en && (beat_idx == beat_idx_t'(BEATS_PER_LINE - 1));

  always_ff @(posedge stb or negedge stb_n)
  begin
    if (!stb_n)
      beat_idx <= '0;
    else if (!fill_active)
      beat_idx <= '0;
    else if (beat_wr_en)
      beat_idx <= beat_idx + 1'b1;
  end

  // Beats only while a fill is open
  no_stray_beat_a: assert property (@(posedge stb) disable iff (!stb_n)
    mem_valid |-> fill_active)
    else $error("mem_valid without an open fill");

endmodule

/* design/cache_ctrl_fsm.sv */
module cache_ctrl_fsm
  import l2_cache_pkg::*;
(
  input  logic stb,
  input  logic stb_n,
  input  logic psel,
  input  logic penable,
  input  logic pwrite,
  input  logic hit,
  input  logic last_beat,
  input  logic mem_ack,
  output logic lookup_en,
  output logic touch,
  output logic word_wr_en,
  output logic fill_active,
  output logic install,
  output logic mem_req,
  output logic pready
);

  typedef enum logic [2:0] {
    st_idle,
    st_lookup,
    st_respond,
    st_fill_req,
    st_fill_data
  } ctrl_state_t;

  ctrl_state_t state_q;
  ctrl_state_t state_d;

  logic setup_phase;
  logic fill_done;

  // APB setup cycle, first half of every transfer
  assign setup_phase = psel && !penable;

  // Eighth beat landing closes the fill
  assign fill_done = (state_q == st_fill_data) && last_beat;

  // Tag lookup at setup, hit/way registered for the first access cycle
  // Also re-issued with install so the new line resolves as a hit
  assign lookup_en = ((state_q == st_idle) && setup_phase) || fill_done;

  assign install     = fill_done;
  assign fill_active = (state_q == st_fill_data);
  assign mem_req     = (state_q == st_fill_req);

  // Response cycle, second access cycle of a hit
  assign pready     = (state_q == st_respond);
  assign touch      = (state_q == st_respond);
  assign word_wr_en = (state_q == st_respond) && pwrite;

  always_comb
  begin
    state_d = state_q;
    case (state_q)
      st_idle:
      begin
        if (setup_phase)
          state_d = st_lookup;
      end
      // Hit result is valid here
      st_lookup:
      begin
        if (hit)
          state_d = st_respond;
        else
          state_d = st_fill_req;
      end
      st_respond:
        state_d = st_idle;
      // Hold the request until memory takes it
      st_fill_req:
      begin
        if (mem_ack)
          state_d = st_fill_data;
      end
      st_fill_data:
      begin
        if (last_beat)
          state_d = st_lookup;
      end
      default:
        state_d = st_idle;
    endcase
  end

  always_ff @(posedge stb or negedge stb_n)
  begin
    if (!stb_n)
      state_q <= st_idle;
    else
      state_q <= state_d;
  end

  // Memory request must not be withdrawn before acknowledge
  mem_req_held_a: assert property (@(posedge stb) disable iff (!stb_n)
    mem_req && !mem_ack |=> mem_req)
    else $error("mem_req dropped before mem_ack");

  // Response only inside an APB access phase
  pready_access_a: assert property (@(posedge stb) disable iff (!stb_n)
    pready |-> psel && penable)
    else $error("pready outside access phase");

endmodule

/* design/l2_cache_top.sv */
module l2_cache_top
  import l2_cache_pkg::*;
(
  input  logic  stb,
  input  logic  stb_n,
  input  logic  psel,
  input  logic  penable,
  input  logic  pwrite,
  input  addr_t paddr,
  input  word_t pwdata,
  output word_t prdata,
  output logic  pready,
  output logic  mem_req,
  output addr_t mem_addr,
  input  logic  mem_ack,
  input  logic  mem_valid,
  input  beat_t mem_rdata
);

  // Address fields of the current transfer
  tag_t      tag;
  index_t    index;
  word_off_t word_off;

  // Controller strobes
  logic lookup_en;
  logic touch;
  logic word_wr_en;
  logic fill_active;
  logic install;

  // Tag side results
  logic hit;
  way_t way;

  // Fill beat tracking
  logic      beat_wr_en;
  beat_idx_t beat_idx;
  logic      last_beat;

  // paddr holds steady for the whole transfer, so the fields do too
  assign tag      = paddr[ADDR_W-1 -: TAG_W];
  assign index    = paddr[LINE_OFF_W +: INDEX_W];
  assign word_off = paddr[BYTE_OFF_W +: WORD_OFF_W];

  // Line address, offset bits cleared
  assign mem_addr = {tag, index, {LINE_OFF_W{1'b0}}};

  cache_ctrl_fsm ctrl_i (
    .stb         (stb),
    .stb_n       (stb_n),
    .psel        (psel),
    .penable     (penable),
    .pwrite      (pwrite),
    .hit         (hit),
    .last_beat   (last_beat),
    .mem_ack     (mem_ack),
    .lookup_en   (lookup_en),
    .touch       (touch),
    .word_wr_en  (word_wr_en),
    .fill_active (fill_active),
    .install     (install),
    .mem_req     (mem_req),
    .pready      (pready)
  );

  burst_counter burst_i (
    .stb         (stb),
    .stb_n       (stb_n),
    .fill_active (fill_active),
    .mem_valid   (mem_valid),
    .beat_wr_en  (beat_wr_en),
    .beat_idx    (beat_idx),
    .last_beat   (last_beat)
  );

  tag_store tags_i (
    .stb       (stb),
    .stb_n     (stb_n),
    .index     (index),
    .tag       (tag),
    .lookup_en (lookup_en),
    .install   (install),
    .touch     (touch),
    .hit       (hit),
    .way       (way)
  );

  data_store data_i (
    .stb        (stb),
    .way        (way),
    .index      (index),
    .word_off   (word_off),
    .pwdata     (pwdata),
    .word_wr_en (word_wr_en),
    .beat_wr_en (beat_wr_en),
    .beat_idx   (beat_idx),
    .mem_rdata  (mem_rdata),
    .prdata     (prdata)
  );

endmodule

/* dv/clk_gen.sv */
module clk_gen
(
  output logic stb,
  output logic stb_n
);

  localparam int HALF_PERIOD  = 2;
  localparam int RESET_CYCLES = 16;

  // Free running clock, period of 4
  initial
  begin
    stb = 1'b0;
    forever
      #HALF_PERIOD stb = ~stb;
  end

  // Reset held low for the first cycles, released just past an edge
  initial
  begin
    stb_n = 1'b0;
    repeat (RESET_CYCLES)
      @(posedge stb);
    #1;
    stb_n = 1'b1;
  end

endmodule

/* dv/mem_model.sv */
module mem_model
  import l2_cache_pkg::*;
(
  input  logic  stb,
  input  logic  stb_n,
  input  logic  mem_req,
  input  addr_t mem_addr,
  output logic  mem_ack,
  output logic  mem_valid,
  output beat_t mem_rdata
);

  integer seed;

  // Memory contents follow the byte address
  function automatic word_t mem_word(input addr_t a);
    return a ^ 32'hc0de0000;
  endfunction

  // Random stall of 0 to 3 idle cycles
  task automatic stall();
    int n;
    n = $unsigned($random(seed)) % 4;
    repeat (n)
    begin
      @(posedge stb);
      #1;
    end
  endtask

  // Acknowledge, then eight beats, low word first
  task automatic send_line(input addr_t line);
    stall();
    mem_ack = 1'b1;
    @(posedge stb);
    #1;
    mem_ack = 1'b0;
    for (int k = 0; k < BEATS_PER_LINE; k++)
    begin
      stall();
      mem_rdata = {mem_word(line + addr_t'(8 * k + 4)), mem_word(line + addr_t'(8 * k))};
      mem_valid = 1'b1;
      @(posedge stb);
      #1;
      mem_valid = 1'b0;
    end
  endtask

  initial
  begin
    seed      = 32'h52b90bb3;
    mem_ack   = 1'b0;
    mem_valid = 1'b0;
    mem_rdata = '0;
    // Poll for a request once per cycle
    forever
    begin
      @(posedge stb);
      #1;
      if (stb_n && mem_req)
        send_line(mem_addr);
    end
  end

endmodule

/* dv/tb_l2_cache.sv */
module tb_l2_cache
  import l2_cache_pkg::*;
();

  localparam int XFER_TIMEOUT  = 200;
  localparam int RESET_TIMEOUT = 100;

  logic  stb;
  logic  stb_n;
  logic  psel;
  logic  penable;
  logic  pwrite;
  addr_t paddr;
  word_t pwdata;
  word_t prdata;
  logic  pready;
  logic  mem_req;
  addr_t mem_addr;
  logic  mem_ack;
  logic  mem_valid;
  beat_t mem_rdata;

  int     errors   = 0;
  int     timeouts = 0;
  int     xfers    = 0;
  bit     hung     = 1'b0;
  integer seed     = 32'h52b90bb3;

  // Expectation for the transfer in flight
  logic  exp_miss  = 1'b0;
  addr_t exp_line  = '0;
  word_t exp_rdata = '0;

  int   req_count;
  logic req_prev;
  logic access_seen;

  // Residency shadow per set and way
  tag_t       res_tag   [NUM_SETS][NUM_WAYS];
  logic       res_valid [NUM_SETS][NUM_WAYS];
  logic [2:0] res_plru  [NUM_SETS];
  // Written words of resident lines only
  word_t      shadow    [addr_t];

  clk_gen clk_i (
    .stb   (stb),
    .stb_n (stb_n)
  );

  mem_model mem_i (
    .stb       (stb),
    .stb_n     (stb_n),
    .mem_req   (mem_req),
    .mem_addr  (mem_addr),
    .mem_ack   (mem_ack),
    .mem_valid (mem_valid),
    .mem_rdata (mem_rdata)
  );

  l2_cache_top dut_i (
    .stb       (stb),
    .stb_n     (stb_n),
    .psel      (psel),
    .penable   (penable),
    .pwrite    (pwrite),
    .paddr     (paddr),
    .pwdata    (pwdata),
    .prdata    (prdata),
    .pready    (pready),
    .mem_req   (mem_req),
    .mem_addr  (mem_addr),
    .mem_ack   (mem_ack),
    .mem_valid (mem_valid),
    .mem_rdata (mem_rdata)
  );

  function void count_error(input string msg);
    errors++;
    $display("%s (time %0t)", msg, $time);
  endfunction

  // Memory requests seen since the last setup cycle
  always_ff @(posedge stb or negedge stb_n)
  begin
    if (!stb_n)
    begin
      req_count   <= 0;
      req_prev    <= 1'b0;
      access_seen <= 1'b0;
    end
    else
    begin
      req_prev <= mem_req;
      if (psel && penable)
        access_seen <= 1'b1;
      if (psel && !penable)
        req_count <= 0;
      else if (mem_req && !req_prev)
        req_count <= req_count + 1;
    end
  end

  quiet_after_reset_a: assert property (@(posedge stb) disable iff (!stb_n)
    !access_seen |-> !pready && !mem_req)
    else count_error("pready or mem_req active before the first access phase");

  pready_in_access_a: assert property (@(posedge stb) disable iff (!stb_n)
    pready |-> psel && penable)
    else count_error("pready high outside an access phase");

  pready_single_a: assert property (@(posedge stb) disable iff (!stb_n)
    pready |=> !pready)
    else count_error("pready high for two cycles in a row");

  // Hit answers in the second access cycle, never the first
  first_access_a: assert property (@(posedge stb) disable iff (!stb_n)
    psel && $rose(penable) |-> !pready)
    else count_error("pready in the first access cycle");

  hit_timing_a: assert property (@(posedge stb) disable iff (!stb_n)
    psel && $rose(penable) && !exp_miss |=> pready)
    else count_error("hit did not complete in the second access cycle");

  read_data_a: assert property (@(posedge stb) disable iff (!stb_n)
    pready && !pwrite |-> prdata == exp_rdata)
    else count_error($sformatf("mismatch prdata got %h exp %h addr %h",
                               $sampled(prdata), exp_rdata, paddr));

  req_addr_a: assert property (@(posedge stb) disable iff (!stb_n)
    $rose(mem_req) |-> mem_addr == exp_line)
    else count_error($sformatf("mismatch mem_addr got %h exp %h",
                               $sampled(mem_addr), exp_line));

  // One fill per miss, none per hit
  req_count_a: assert property (@(posedge stb) disable iff (!stb_n)
    pready |-> req_count == (exp_miss ? 1 : 0))
    else count_error($sformatf("mismatch req_count got %h exp %h",
                               req_count, exp_miss ? 1 : 0));

  req_addr_stable_a: assert property (@(posedge stb) disable iff (!stb_n)
    mem_req && !mem_ack |=> $stable(mem_addr))
    else count_error("mem_addr changed while mem_req waited for mem_ack");

  function automatic addr_t line_addr(input tag_t t, input index_t s);
    return {t, s, 6'b0};
  endfunction

  function automatic word_t expected_word(input addr_t a);
    return shadow.exists(a) ? shadow[a] : (a ^ 32'hc0de0000);
  endfunction

  // Tree points away from the way just used
  function void touch_way(input index_t s, input int w);
    case (w)
      0:
      begin
        res_plru[s][2] = 1'b1;
        res_plru[s][1] = 1'b1;
      end
      1:
      begin
        res_plru[s][2] = 1'b1;
        res_plru[s][1] = 1'b0;
      end
      2:
      begin
        res_plru[s][2] = 1'b0;
        res_plru[s][0] = 1'b1;
      end
      default:
      begin
        res_plru[s][2] = 1'b0;
        res_plru[s][0] = 1'b0;
      end
    endcase
  endfunction

  // Lowest empty way first, else follow the tree
  function automatic int pick_victim(input index_t s);
    int v;
    v = -1;
    for (int w = 0; w < NUM_WAYS; w++)
      if (v < 0 && !res_valid[s][w])
        v = w;
    if (v < 0)
    begin
      if (res_plru[s][2])
        v = res_plru[s][0] ? 3 : 2;
      else
        v = res_plru[s][1] ? 1 : 0;
    end
    return v;
  endfunction

  // Returns 1 on a predicted miss, updates residency
  function automatic logic model_access(input addr_t a);
    tag_t   t;
    index_t s;
    int     hit_w;
    int     v;
    addr_t  old_line;
    t     = a[31:12];
    s     = a[11:6];
    hit_w = -1;
    for (int w = 0; w < NUM_WAYS; w++)
      if (res_valid[s][w] && res_tag[s][w] == t)
        hit_w = w;
    if (hit_w >= 0)
    begin
      touch_way(s, hit_w);
      return 1'b0;
    end
    v = pick_victim(s);
    // Evicted line is dropped, written words go with it
    if (res_valid[s][v])
    begin
      old_line = line_addr(res_tag[s][v], s);
      for (int k = 0; k < WORDS_PER_LINE; k++)
        shadow.delete(old_line + addr_t'(4 * k));
    end
    res_valid[s][v] = 1'b1;
    res_tag[s][v]   = t;
    touch_way(s, v);
    return 1'b1;
  endfunction

  task automatic idle_cycles(input int n);
    repeat (n)
    begin
      @(posedge stb);
      #1;
    end
  endtask

  // One APB transfer, setup then access until pready
  task automatic apb_xfer(input logic wr, input addr_t a, input word_t wd);
    int   cycles;
    logic done;
    if (hung)
      return;
    exp_miss  = model_access(a);
    exp_line  = {a[31:6], 6'b0};
    exp_rdata = expected_word(a);
    pwrite    = wr;
    paddr     = a;
    pwdata    = wd;
    psel      = 1'b1;
    penable   = 1'b0;
    @(posedge stb);
    #1;
    penable = 1'b1;
    cycles  = 0;
    done    = 1'b0;
    while (!done && cycles < XFER_TIMEOUT)
    begin
      @(negedge stb);
      done = pready;
      cycles++;
    end
    @(posedge stb);
    #1;
    psel    = 1'b0;
    penable = 1'b0;
    xfers++;
    if (!done)
    begin
      timeouts++;
      hung = 1'b1;
      $display("timeout: transfer to %h never got pready", a);
    end
    else if (wr)
      shadow[a] = wd;
  endtask

  task automatic read_line(input addr_t base);
    for (int w = 0; w < WORDS_PER_LINE; w++)
      apb_xfer(1'b0, base + addr_t'(4 * w), '0);
  endtask

  task automatic finish_run();
    $display("transfers %0d, errors %0d, timeouts %0d", xfers, errors, timeouts);
    if (errors == 0 && timeouts == 0)
      $display("SIMULATION PASSED");
    else
      $display("SIMULATION FAILED");
    $finish;
  endtask

  initial
  begin
    addr_t a;
    word_t d;
    int    cycles;
    psel    = 1'b0;
    penable = 1'b0;
    pwrite  = 1'b0;
    paddr   = '0;
    pwdata  = '0;
    for (int s = 0; s < NUM_SETS; s++)
    begin
      res_plru[s] = '0;
      for (int w = 0; w < NUM_WAYS; w++)
        res_valid[s][w] = 1'b0;
    end
    cycles = 0;
    while (stb_n !== 1'b1 && cycles < RESET_TIMEOUT)
    begin
      @(posedge stb);
      cycles++;
    end
    if (stb_n !== 1'b1)
    begin
      timeouts++;
      hung = 1'b1;
      $display("timeout: reset was never released");
    end
    idle_cycles(3);
    // Cold miss, then 15 hits on the same line
    read_line(line_addr(20'h00041, 6'd1));
    // Write hit and read back
    a = line_addr(20'h00041, 6'd1) + 32'd12;
    apb_xfer(1'b1, a, 32'h1234abcd);
    apb_xfer(1'b0, a, '0);
    // Write miss merges into the fetched line
    apb_xfer(1'b1, line_addr(20'h00a5c, 6'd2) + 32'd20, 32'h5a5a0f0f);
    read_line(line_addr(20'h00a5c, 6'd2));
    // Random words and idle gaps on fresh lines
    for (int i = 0; i < 6; i++)
    begin
      a = line_addr(tag_t'(32'h200 + i), index_t'(8 + i));
      a = a + addr_t'(4 * ($unsigned($random(seed)) % 16));
      d = $random(seed);
      apb_xfer(1'b1, a, d);
      idle_cycles($unsigned($random(seed)) % 3);
      apb_xfer(1'b0, a, '0);
      read_line(a & ~addr_t'(63));
    end
    // Lines A to E in set 20, E pushes out A
    for (int i = 0; i < 5; i++)
      apb_xfer(1'b0, line_addr(tag_t'(32'h100 + i), 6'd20) + 32'd8, '0);
    // B stays, A comes back over C, D stays, C refetched
    apb_xfer(1'b0, line_addr(20'h00101, 6'd20) + 32'd4, '0);
    apb_xfer(1'b0, line_addr(20'h00100, 6'd20) + 32'd60, '0);
    apb_xfer(1'b0, line_addr(20'h00103, 6'd20), '0);
    apb_xfer(1'b0, line_addr(20'h00102, 6'd20) + 32'd36, '0);
    idle_cycles(4);
    finish_run();
  end

endmodule

/* run_sim.sh */
#!/bin/sh
# Compile and run the L2 cache testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log
BIN=tb_l2_cache_sim

rm -rf obj_dir

verilator --binary --timing --assert \
  --top-module tb_l2_cache \
  -f sources.f \
  -o "$BIN"
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/"$BIN" > "$LOG" 2>&1
run_status=$?
cat "$LOG"
if [ $run_status -ne 0 ]; then
  echo "Simulation exited with status $run_status"
  exit 1
fi

if grep -q "SIMULATION FAILED" "$LOG"; then
  exit 1
fi
if ! grep -q "SIMULATION PASSED" "$LOG"; then
  echo "No result line found in $LOG"
  exit 1
fi
exit 0

/* sources.f */
common/l2_cache_pkg.sv
cache_array/tag_store.sv
cache_array/data_store.sv
design/burst_counter.sv
design/cache_ctrl_fsm.sv
design/l2_cache_top.sv
dv/clk_gen.sv
dv/mem_model.sv
dv/tb_l2_cache.sv
